// File: src/solver_pkg.sv
// ********************
// Shared widths, defaults and the queue item types of the equation solver
// Every solver module imports this package by wildcard
// ********************

package solver_pkg;

    localparam int DATA_W = 64;
    localparam int FRAC_W = 8;
    localparam int COEF_W = 8;
    localparam int TAG_W  = 8;

    localparam int N_UNK_DEFAULT      = 3;
    localparam int FIFO_DEPTH_DEFAULT = 4;

    // Wide enough for the largest supported system plus one
    localparam int IDX_W = $clog2(N_UNK_DEFAULT + 1);

    // One division request, numerator still unscaled
    typedef struct packed {
        logic [TAG_W-1:0]  tag;
        logic [IDX_W-1:0]  idx;
        logic [DATA_W-1:0] num;
        logic [DATA_W-1:0] den;
    } div_job_t;

    // One fixed-point unknown with FRAC_W fraction bits
    typedef struct packed {
        logic [TAG_W-1:0]  tag;
        logic [IDX_W-1:0]  idx;
        logic [DATA_W-1:0] quot;
        logic              singular;
    } div_result_t;

endpackage

// File: src/pivot_select.sv
// ********************
// Pivot search for one column of the elimination matrix
// Picks the largest magnitude among rows not yet used, one cycle of latency
// ********************

module pivot_select
    import solver_pkg::*;
#(
    parameter int N_UNK = N_UNK_DEFAULT
) (
    input  logic                         clk_i,
    input  logic                         rst_n_i,
    input  logic [IDX_W-1:0]             col_i,
    input  logic [N_UNK-1:0]             mask_i,
    input  logic [N_UNK-1:0][DATA_W-1:0] col_vals_i,
    output logic [IDX_W-1:0]             pivot_row_o,
    output logic [DATA_W-1:0]            pivot_val_o
);

    logic [IDX_W-1:0]  best_row;
    logic [DATA_W-1:0] best_val;
    logic [DATA_W-1:0] best_mag;
    logic [DATA_W-1:0] mag;
    logic              found;

    // A full mask leaves the diagonal row with a zero pivot
    always_comb begin
        best_row = col_i;
        best_val = '0;
        best_mag = '0;
        mag      = '0;
        found    = 1'b0;
        for (int i = 0; i < N_UNK; i++) begin
            mag = col_vals_i[i][DATA_W-1] ? -col_vals_i[i] : col_vals_i[i];
            // Strict compare keeps the lowest row on a tie
            if (!mask_i[i] && (!found || mag > best_mag)) begin
                found    = 1'b1;
                best_row = IDX_W'(i);
                best_val = col_vals_i[i];
                best_mag = mag;
            end
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pivot_row_o <= '0;
            pivot_val_o <= '0;
        end else begin
            pivot_row_o <= best_row;
            pivot_val_o <= best_val;
        end
    end

endmodule

// File: src/elim_engine.sv
// ********************
// Fraction-free Gauss-Jordan elimination with partial pivoting
// Two cycles per column, then one division job per unknown in column order
// ********************

module elim_engine
    import solver_pkg::*;
#(
    parameter int N_UNK = N_UNK_DEFAULT
) (
    input  logic                                  clk_i,
    input  logic                                  rst_n_i,
    input  logic                                  start_valid_i,
    output logic                                  start_ready_o,
    input  logic [N_UNK-1:0][N_UNK:0][COEF_W-1:0] coef_i,
    input  logic [TAG_W-1:0]                      tag_i,
    output logic                                  job_valid_o,
    output div_job_t                              job_o,
    input  logic                                  job_ready_i
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_SEARCH,
        ST_UPDATE,
        ST_EMIT
    } state_t;

    localparam logic [IDX_W-1:0] LAST_COL = IDX_W'(N_UNK - 1);

    state_t                       state;
    logic [IDX_W-1:0]             col;
    logic [N_UNK-1:0]             used_mask;
    logic [IDX_W-1:0]             piv_tbl [N_UNK];
    logic signed [DATA_W-1:0]     mat [N_UNK][N_UNK+1];
    logic [TAG_W-1:0]             tag_q;
    logic [N_UNK-1:0][DATA_W-1:0] col_vals;
    logic [IDX_W-1:0]             pivot_row;
    logic signed [DATA_W-1:0]     pivot_val;
    logic [IDX_W-1:0]             emit_row;

    always_comb begin
        for (int i = 0; i < N_UNK; i++) begin
            col_vals[i] = mat[i][col];
        end
    end

    pivot_select #(
        .N_UNK(N_UNK)
    ) i_pivot (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .col_i      (col),
        .mask_i     (used_mask),
        .col_vals_i (col_vals),
        .pivot_row_o(pivot_row),
        .pivot_val_o(pivot_val)
    );

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state     <= ST_IDLE;
            col       <= '0;
            used_mask <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (start_valid_i) begin
                        state     <= ST_SEARCH;
                        col       <= '0;
                        used_mask <= '0;
                    end
                end
                ST_SEARCH: begin
                    state <= ST_UPDATE;
                end
                ST_UPDATE: begin
                    used_mask <= used_mask | (N_UNK'(1) << pivot_row);
                    if (col == LAST_COL) begin
                        state <= ST_EMIT;
                        col   <= '0;
                    end else begin
                        state <= ST_SEARCH;
                        col   <= col + 1'b1;
                    end
                end
                default: begin
                    // The column counter doubles as the job index here
                    if (job_ready_i) begin
                        if (col == LAST_COL) begin
                            state <= ST_IDLE;
                            col   <= '0;
                        end else begin
                            col <= col + 1'b1;
                        end
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (state == ST_IDLE && start_valid_i) begin
            tag_q <= tag_i;
            for (int i = 0; i < N_UNK; i++) begin
                for (int j = 0; j <= N_UNK; j++) begin
                    mat[i][j] <= {{(DATA_W-COEF_W){coef_i[i][j][COEF_W-1]}}, coef_i[i][j]};
                end
            end
        end else if (state == ST_UPDATE) begin
            piv_tbl[col] <= pivot_row;
            // The pivot row itself is kept as it is
            for (int i = 0; i < N_UNK; i++) begin
                if (IDX_W'(i) != pivot_row) begin
                    for (int j = 0; j <= N_UNK; j++) begin
                        mat[i][j] <= pivot_val * mat[i][j] - mat[i][col] * mat[pivot_row][j];
                    end
                end
            end
        end
    end

    assign start_ready_o = (state == ST_IDLE);
    assign job_valid_o   = (state == ST_EMIT);

    assign emit_row  = piv_tbl[col];
    assign job_o.tag = tag_q;
    assign job_o.idx = col;
    assign job_o.num = mat[emit_row][N_UNK];
    assign job_o.den = mat[emit_row][col];

endmodule

// File: src/sync_fifo.sv
// ********************
// Single-clock queue with valid/ready on both sides
// The payload type is a parameter, so jobs and results share this code
// ********************

module sync_fifo
    import solver_pkg::*;
#(
    parameter type item_t = div_job_t,
    parameter int  DEPTH  = FIFO_DEPTH_DEFAULT
) (
    input  logic  clk_i,
    input  logic  rst_n_i,
    input  logic  wr_valid_i,
    output logic  wr_ready_o,
    input  item_t wr_data_i,
    output logic  rd_valid_o,
    input  logic  rd_ready_i,
    output item_t rd_data_o
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    item_t            mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_wr;
    logic             do_rd;

    assign wr_ready_o = (count != CNT_W'(DEPTH));
    assign rd_valid_o = (count != '0);
    assign rd_data_o  = mem[rd_ptr];

    assign do_wr = wr_valid_i && wr_ready_o;
    assign do_rd = rd_valid_o && rd_ready_i;

    always_ff @(posedge clk_i) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_data_i;
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + CNT_W'(do_wr) - CNT_W'(do_rd);
        end
    end

endmodule

// File: src/serial_divider.sv
// ********************
// Signed restoring divider, one quotient bit per cycle
// Quotient truncates toward zero; it is held until the consumer takes it
// ********************

module serial_divider
    import solver_pkg::*;
(
    input  logic              clk_i,
    input  logic              rst_n_i,
    input  logic              op_valid_i,
    output logic              op_ready_o,
    input  logic [DATA_W-1:0] dividend_i,
    input  logic [DATA_W-1:0] divisor_i,
    output logic              q_valid_o,
    input  logic              q_ready_i,
    output logic [DATA_W-1:0] quotient_o,
    output logic              div_zero_o
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_PREP,
        ST_RUN,
        ST_FIX,
        ST_DONE
    } state_t;

    state_t                      state;
    logic [$clog2(DATA_W)-1:0]   cnt;
    logic [DATA_W-1:0]           dvd;
    logic [DATA_W-1:0]           dvs;
    logic [DATA_W:0]             rem;
    logic [DATA_W:0]             shifted;
    logic                        neg;
    logic                        zero;

    assign op_ready_o = (state == ST_IDLE);
    assign q_valid_o  = (state == ST_DONE);
    assign shifted    = {rem[DATA_W-1:0], dvd[DATA_W-1]};

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state <= ST_IDLE;
            cnt   <= '0;
        end else begin
            case (state)
                ST_IDLE: if (op_valid_i) state <= ST_PREP;
                ST_PREP: begin
                    state <= ST_RUN;
                    cnt   <= '0;
                end
                ST_RUN: begin
                    cnt <= cnt + 1'b1;
                    if (cnt == ($clog2(DATA_W))'(DATA_W - 1)) state <= ST_FIX;
                end
                ST_FIX:  state <= ST_DONE;
                default: if (q_ready_i) state <= ST_IDLE;
            endcase
        end
    end

    // The dividend register fills with quotient bits from the right
    always_ff @(posedge clk_i) begin
        case (state)
            ST_IDLE: begin
                dvd <= dividend_i;
                dvs <= divisor_i;
            end
            ST_PREP: begin
                neg  <= dvd[DATA_W-1] ^ dvs[DATA_W-1];
                zero <= (dvs == '0);
                dvd  <= dvd[DATA_W-1] ? -dvd : dvd;
                dvs  <= dvs[DATA_W-1] ? -dvs : dvs;
                rem  <= '0;
            end
            ST_RUN: begin
                if (shifted >= {1'b0, dvs}) begin
                    rem <= shifted - {1'b0, dvs};
                    dvd <= {dvd[DATA_W-2:0], 1'b1};
                end else begin
                    rem <= shifted;
                    dvd <= {dvd[DATA_W-2:0], 1'b0};
                end
            end
            ST_FIX: begin
                quotient_o <= zero ? '0 : (neg ? -dvd : dvd);
                div_zero_o <= zero;
            end
            default: ;
        endcase
    end

endmodule

// File: src/div_cluster.sv
// ********************
// Two divider lanes fed from one job stream
// Completed lanes are merged by a fixed-priority arbiter, lane 0 first
// ********************

module div_cluster
    import solver_pkg::*;
(
    input  logic        clk_i,
    input  logic        rst_n_i,
    input  logic        job_valid_i,
    output logic        job_ready_o,
    input  div_job_t    job_i,
    output logic        res_valid_o,
    input  logic        res_ready_i,
    output div_result_t res_o
);

    localparam int LANES = 2;

    logic [LANES-1:0]  op_valid;
    logic [LANES-1:0]  op_ready;
    logic [LANES-1:0]  q_valid;
    logic [LANES-1:0]  q_ready;
    logic [LANES-1:0]  div_zero;
    logic [DATA_W-1:0] quot [LANES];
    logic [TAG_W-1:0]  lane_tag [LANES];
    logic [IDX_W-1:0]  lane_idx [LANES];
    logic [DATA_W-1:0] scaled_num;
    logic              sel;
    logic              lock;
    logic              lock_sel;

    assign scaled_num = job_i.num << FRAC_W;

    // Lowest-numbered idle lane takes the job
    assign job_ready_o = |op_ready;
    assign op_valid[0] = job_valid_i && op_ready[0];
    assign op_valid[1] = job_valid_i && op_ready[1] && !op_ready[0];

    for (genvar k = 0; k < LANES; k++) begin : g_lane
        serial_divider i_div (
            .clk_i     (clk_i),
            .rst_n_i   (rst_n_i),
            .op_valid_i(op_valid[k]),
            .op_ready_o(op_ready[k]),
            .dividend_i(scaled_num),
            .divisor_i (job_i.den),
            .q_valid_o (q_valid[k]),
            .q_ready_i (q_ready[k]),
            .quotient_o(quot[k]),
            .div_zero_o(div_zero[k])
        );

        always_ff @(posedge clk_i) begin
            if (op_valid[k]) begin
                lane_tag[k] <= job_i.tag;
                lane_idx[k] <= job_i.idx;
            end
        end
    end

    // A presented result stays selected until the queue takes it
    assign sel         = lock ? lock_sel : !q_valid[0];
    assign res_valid_o = |q_valid;
    assign q_ready[0]  = res_ready_i && q_valid[0] && !sel;
    assign q_ready[1]  = res_ready_i && q_valid[1] && sel;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            lock     <= 1'b0;
            lock_sel <= 1'b0;
        end else begin
            lock     <= res_valid_o && !res_ready_i;
            lock_sel <= sel;
        end
    end

    assign res_o.tag      = lane_tag[sel];
    assign res_o.idx      = lane_idx[sel];
    assign res_o.quot     = quot[sel];
    assign res_o.singular = div_zero[sel];

endmodule

// File: src/equation_solver.sv
// ********************
// Linear system solver top level
// Elimination engine, job queue, two-lane divider cluster and result queue
// ********************

module equation_solver
    import solver_pkg::*;
#(
    parameter int N_UNK      = N_UNK_DEFAULT,
    parameter int FIFO_DEPTH = FIFO_DEPTH_DEFAULT
) (
    input  logic                                  clk_i,
    input  logic                                  rst_n_i,
    input  logic                                  start_valid_i,
    output logic                                  start_ready_o,
    input  logic [N_UNK-1:0][N_UNK:0][COEF_W-1:0] coef_i,
    input  logic [TAG_W-1:0]                      tag_i,
    output logic                                  result_valid_o,
    input  logic                                  result_ready_i,
    output logic [TAG_W-1:0]                      result_tag_o,
    output logic [IDX_W-1:0]                      result_index_o,
    output logic [DATA_W-1:0]                     result_value_o,
    output logic                                  result_singular_o
);

    logic        eng_job_valid;
    logic        eng_job_ready;
    div_job_t    eng_job;
    logic        q_job_valid;
    logic        q_job_ready;
    div_job_t    q_job;
    logic        cl_res_valid;
    logic        cl_res_ready;
    div_result_t cl_res;
    div_result_t out_res;

    elim_engine #(
        .N_UNK(N_UNK)
    ) i_engine (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .start_valid_i(start_valid_i),
        .start_ready_o(start_ready_o),
        .coef_i       (coef_i),
        .tag_i        (tag_i),
        .job_valid_o  (eng_job_valid),
        .job_o        (eng_job),
        .job_ready_i  (eng_job_ready)
    );

    sync_fifo #(
        .item_t(div_job_t),
        .DEPTH (FIFO_DEPTH)
    ) i_job_fifo (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .wr_valid_i(eng_job_valid),
        .wr_ready_o(eng_job_ready),
        .wr_data_i (eng_job),
        .rd_valid_o(q_job_valid),
        .rd_ready_i(q_job_ready),
        .rd_data_o (q_job)
    );

    div_cluster i_cluster (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .job_valid_i(q_job_valid),
        .job_ready_o(q_job_ready),
        .job_i      (q_job),
        .res_valid_o(cl_res_valid),
        .res_ready_i(cl_res_ready),
        .res_o      (cl_res)
    );

    sync_fifo #(
        .item_t(div_result_t),
        .DEPTH (FIFO_DEPTH)
    ) i_res_fifo (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .wr_valid_i(cl_res_valid),
        .wr_ready_o(cl_res_ready),
        .wr_data_i (cl_res),
        .rd_valid_o(result_valid_o),
        .rd_ready_i(result_ready_i),
        .rd_data_o (out_res)
    );

    assign result_tag_o      = out_res.tag;
    assign result_index_o    = out_res.idx;
    assign result_value_o    = out_res.quot;
    assign result_singular_o = out_res.singular;

endmodule

// File: verification/tb_clock_gen.sv
// ********************
// Testbench clock and reset source
// 8 ns clock, active-low reset held for 4 rising edges
// ********************

module tb_clock_gen (
    output logic clk_o,
    output logic rst_n_o
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int HALF_PERIOD  = 4;
    localparam int RESET_CYCLES = 4;

    initial begin
        clk_o = 1'b0;
        forever begin
            #HALF_PERIOD;
            clk_o = ~clk_o;
        end
    end

    // Release lands 1 ns after an edge, like all other stimulus
    initial begin
        rst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        #1;
        rst_n_o = 1'b1;
    end

endmodule

// File: verification/solver_tb.sv
// ********************
// Testbench for the equation solver
// Random and directed systems are checked against a reference model
// through a scoreboard keyed by tag and unknown index
// ********************

module solver_tb
    import solver_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int N_UNK         = 3;
    localparam int START_TIMEOUT = 5000;
    localparam int DRAIN_TIMEOUT = 40000;
    localparam int IDLE_CYCLES   = 100;

    logic                                  clk;
    logic                                  rst_n;
    logic                                  start_valid;
    logic                                  start_ready;
    logic [N_UNK-1:0][N_UNK:0][COEF_W-1:0] coef;
    logic [TAG_W-1:0]                      tag;
    logic                                  result_valid;
    logic                                  result_ready;
    logic [TAG_W-1:0]                      result_tag;
    logic [IDX_W-1:0]                      result_index;
    logic [DATA_W-1:0]                     result_value;
    logic                                  result_singular;

    logic signed [COEF_W-1:0] stim [N_UNK][N_UNK+1];
    longint                   mdl_val [N_UNK];
    bit                       mdl_sing [N_UNK];
    longint                   sb_val [256][N_UNK];
    bit                       sb_sing [256][N_UNK];
    bit                       sb_pend [256][N_UNK];

    int               seed;
    int               starts_accepted;
    int               results_seen;
    int               singular_seen;
    int               hold_cnt;
    bit               bp_mode;
    logic [TAG_W-1:0] next_tag;

    tb_clock_gen i_clk_gen (
        .clk_o  (clk),
        .rst_n_o(rst_n)
    );

    equation_solver #(
        .N_UNK     (N_UNK),
        .FIFO_DEPTH(4)
    ) i_dut (
        .clk_i            (clk),
        .rst_n_i          (rst_n),
        .start_valid_i    (start_valid),
        .start_ready_o    (start_ready),
        .coef_i           (coef),
        .tag_i            (tag),
        .result_valid_o   (result_valid),
        .result_ready_i   (result_ready),
        .result_tag_o     (result_tag),
        .result_index_o   (result_index),
        .result_value_o   (result_value),
        .result_singular_o(result_singular)
    );

    task automatic stop_with_failure();
        $display("Verification failed");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    // Fraction-free Gauss-Jordan with partial pivoting on the current stimulus
    task automatic model_system();
        longint m [N_UNK][N_UNK+1];
        longint nm [N_UNK][N_UNK+1];
        bit     used [N_UNK];
        int     piv [N_UNK];
        int     p;
        longint mag;
        longint best;
        longint num;
        longint den;
        for (int i = 0; i < N_UNK; i++) begin
            used[i] = 1'b0;
            for (int j = 0; j <= N_UNK; j++) begin
                m[i][j] = longint'(stim[i][j]);
            end
        end
        for (int k = 0; k < N_UNK; k++) begin
            p    = -1;
            best = 0;
            for (int i = 0; i < N_UNK; i++) begin
                mag = (m[i][k] < 0) ? -m[i][k] : m[i][k];
                if (!used[i] && (p < 0 || mag > best)) begin
                    p    = i;
                    best = mag;
                end
            end
            used[p] = 1'b1;
            piv[k]  = p;
            nm      = m;
            for (int i = 0; i < N_UNK; i++) begin
                if (i != p) begin
                    for (int j = 0; j <= N_UNK; j++) begin
                        nm[i][j] = m[p][k] * m[i][j] - m[i][k] * m[p][j];
                    end
                end
            end
            m = nm;
        end
        for (int k = 0; k < N_UNK; k++) begin
            num = m[piv[k]][N_UNK];
            den = m[piv[k]][k];
            mdl_sing[k] = (den == 0);
            if (den == 0) begin
                mdl_val[k] = 0;
            end else begin
                mdl_val[k] = (num <<< FRAC_W) / den;
            end
        end
    endtask

    task automatic fill_random_system();
        for (int i = 0; i < N_UNK; i++) begin
            for (int j = 0; j <= N_UNK; j++) begin
                stim[i][j] = COEF_W'($random(seed) % 8);
            end
        end
    endtask

    task automatic set_row(input int i, input int a0, input int a1, input int a2, input int b);
        stim[i][0] = COEF_W'(a0);
        stim[i][1] = COEF_W'(a1);
        stim[i][2] = COEF_W'(a2);
        stim[i][3] = COEF_W'(b);
    endtask

    task automatic make_nonsingular_system();
        int tries;
        bit bad;
        tries = 0;
        bad   = 1'b1;
        while (bad) begin
            if (tries >= 100) begin
                $display("No nonsingular random system found within 100 tries");
                stop_with_failure();
            end
            fill_random_system();
            model_system();
            bad = 1'b0;
            for (int k = 0; k < N_UNK; k++) begin
                if (mdl_sing[k]) begin
                    bad = 1'b1;
                end
            end
            tries++;
        end
    endtask

    // Called 1 ns after an edge; returns 1 ns after the edge that took the system
    task automatic start_system();
        int waited;
        model_system();
        for (int k = 0; k < N_UNK; k++) begin
            sb_val[next_tag][k]  = mdl_val[k];
            sb_sing[next_tag][k] = mdl_sing[k];
            sb_pend[next_tag][k] = 1'b1;
        end
        start_valid = 1'b1;
        tag         = next_tag;
        for (int i = 0; i < N_UNK; i++) begin
            for (int j = 0; j <= N_UNK; j++) begin
                coef[i][j] = stim[i][j];
            end
        end
        waited = 0;
        while (start_ready !== 1'b1) begin
            if (waited >= START_TIMEOUT) begin
                $display("Timeout: start_ready_o stayed low for %0d cycles", waited);
                stop_with_failure();
            end
            @(posedge clk);
            #1;
            waited++;
        end
        @(posedge clk);
        #1;
        starts_accepted++;
        next_tag++;
        start_valid = 1'b0;
    endtask

    task automatic wait_for_drain();
        int waited;
        waited = 0;
        while (results_seen != N_UNK * starts_accepted) begin
            if (waited >= DRAIN_TIMEOUT) begin
                $display("Timeout: only %0d of %0d results arrived", results_seen,
                         N_UNK * starts_accepted);
                stop_with_failure();
            end
            @(posedge clk);
            #1;
            waited++;
        end
    endtask

    task automatic check_result();
        logic [TAG_W-1:0] t;
        int               idx;
        t   = result_tag;
        idx = int'(result_index);
        assert (idx < N_UNK) else begin
            $display("Result with tag %0d carries index %0d outside the system", t, idx);
            stop_with_failure();
        end
        assert (sb_pend[t][idx]) else begin
            $display("Result for tag %0d index %0d was not expected or came twice", t, idx);
            stop_with_failure();
        end
        assert (result_value === sb_val[t][idx]) else begin
            $display("CHECK FAILED at %0t: result_value_o (tag %0d index %0d) %s %0d got %0d",
                     $time, t, idx, "expected", sb_val[t][idx], $signed(result_value));
            stop_with_failure();
        end
        assert (result_singular === sb_sing[t][idx]) else begin
            $display("CHECK FAILED at %0t: result_singular_o (tag %0d index %0d) %s %0b got %0b",
                     $time, t, idx, "expected", sb_sing[t][idx], result_singular);
            stop_with_failure();
        end
        sb_pend[t][idx] = 1'b0;
        results_seen++;
        if (result_singular) begin
            singular_seen++;
        end
    endtask

    always @(posedge clk) begin
        if (rst_n === 1'b1 && result_valid === 1'b1 && result_ready === 1'b1) begin
            check_result();
        end
    end

    // Under back-pressure, short and long low stretches alternate with short high ones
    always begin
        @(posedge clk);
        #1;
        if (!bp_mode) begin
            result_ready = 1'b1;
        end else if (hold_cnt > 0) begin
            hold_cnt--;
        end else if (result_ready) begin
            result_ready = 1'b0;
            if ($random(seed) & 1) begin
                hold_cnt = 1 + int'($unsigned($random(seed)) % 4);
            end else begin
                hold_cnt = 20 + int'($unsigned($random(seed)) % 60);
            end
        end else begin
            result_ready = 1'b1;
            hold_cnt     = int'($unsigned($random(seed)) % 6);
        end
    end

    initial begin
        int waited;
        int sing_before;
        seed            = 36220;
        start_valid     = 1'b0;
        coef            = '0;
        tag             = '0;
        result_ready    = 1'b1;
        bp_mode         = 1'b0;
        hold_cnt        = 0;
        starts_accepted = 0;
        results_seen    = 0;
        singular_seen   = 0;
        next_tag        = '0;

        waited = 0;
        while (rst_n !== 1'b1) begin
            if (waited >= 20) begin
                $display("Timeout: reset was never released");
                stop_with_failure();
            end
            @(posedge clk);
            waited++;
        end
        @(posedge clk);
        #1;
        assert (start_ready === 1'b1) else begin
            $display("CHECK FAILED at %0t: start_ready_o expected 1 got %b", $time, start_ready);
            stop_with_failure();
        end
        assert (result_valid === 1'b0) else begin
            $display("CHECK FAILED at %0t: result_valid_o expected 0 got %b", $time, result_valid);
            stop_with_failure();
        end

        repeat (40) begin
            make_nonsingular_system();
            start_system();
        end
        wait_for_drain();

        // A zero column, then two equal rows
        sing_before = singular_seen;
        set_row(0, 3, 0, -2, 5);
        set_row(1, -4, 0, 6, 1);
        set_row(2, 2, 0, 7, -3);
        start_system();
        set_row(0, 2, -3, 5, 4);
        set_row(1, 2, -3, 5, 4);
        set_row(2, -6, 1, 7, 2);
        start_system();
        wait_for_drain();
        assert (singular_seen > sing_before) else begin
            $display("Singular systems produced no result with the singular flag");
            stop_with_failure();
        end

        // Largest entries in later rows, then tied magnitudes
        set_row(0, 1, 2, 3, 4);
        set_row(1, 2, -1, 1, 3);
        set_row(2, 7, 1, -2, 5);
        start_system();
        set_row(0, -1, 3, 2, 6);
        set_row(1, 2, 1, -7, -4);
        set_row(2, 3, -5, 1, 2);
        start_system();
        set_row(0, -5, 1, 2, 3);
        set_row(1, 5, 2, -1, 4);
        set_row(2, 3, -3, 4, -2);
        start_system();
        set_row(0, 4, -6, 1, 2);
        set_row(1, -4, 6, 3, 1);
        set_row(2, 2, 6, -5, 7);
        start_system();
        wait_for_drain();

        bp_mode = 1'b1;
        repeat (20) begin
            fill_random_system();
            start_system();
        end
        wait_for_drain();
        bp_mode = 1'b0;

        // Any stray result in this window hits the scoreboard
        repeat (IDLE_CYCLES) begin
            @(posedge clk);
        end
        #1;
        assert (start_ready === 1'b1) else begin
            $display("CHECK FAILED at %0t: start_ready_o expected 1 got %b", $time, start_ready);
            stop_with_failure();
        end
        assert (result_valid === 1'b0) else begin
            $display("CHECK FAILED at %0t: result_valid_o expected 0 got %b", $time, result_valid);
            stop_with_failure();
        end

        if (results_seen == N_UNK * starts_accepted) begin
            $display("Verification passed");
            $finish;
        end else begin
            $display("CHECK FAILED at %0t: result count expected %0d got %0d", $time,
                     N_UNK * starts_accepted, results_seen);
            stop_with_failure();
        end
    end

endmodule

// File: compile.f
src/solver_pkg.sv
src/pivot_select.sv
src/elim_engine.sv
src/sync_fifo.sv
src/serial_divider.sv
src/div_cluster.sv
src/equation_solver.sv
verification/tb_clock_gen.sv
verification/solver_tb.sv

// File: run.sh
#!/bin/sh
# Builds the equation solver testbench with Verilator and runs it.
# The pass message in the log decides the exit status.
set -e

cd "$(dirname "$0")"
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f compile.f --top-module solver_tb -o solver_sim

./obj_dir/solver_sim | tee sim.log

if grep -q "Verification passed" sim.log; then
    echo "Simulation result: PASS"
else
    echo "Simulation result: FAIL"
    exit 1
fi
